//--- bench/ghostStepAsserts.sv
`timescale 1ns/10ps

module ghostStepAsserts (
    input logic          sysclk,
    input logic          rstN,
    input logic          outValid,
    input logic          outReady,
    input mazePkg::tileT nextLoc,
    input mazePkg::dirT  nextFacing
);
    int failCount = 0; // Read by the testbench

    // Pipe empty right after a reset edge
    resetClears: assert property (@(posedge sysclk) !rstN |=> !outValid)
        else begin
            $error("outValid high in the cycle after reset");
            failCount++;
        end

    // Result held while the consumer stalls
    holdOnStall: assert property (@(posedge sysclk) disable iff (!rstN)
        (outValid && !outReady) |=> (outValid && $stable(nextLoc) && $stable(nextFacing)))
        else begin
            $error("Output changed or dropped during back-pressure");
            failCount++;
        end

    facingOneHot: assert property (@(posedge sysclk) disable iff (!rstN)
        outValid |-> $onehot(nextFacing))
        else begin
            $error("nextFacing not one-hot while outValid");
            failCount++;
        end

endmodule

bind ghostStepTop ghostStepAsserts uAsserts (
    .sysclk(sysclk), .rstN(rstN), .outValid(outValid), .outReady(outReady),
    .nextLoc(nextLoc), .nextFacing(nextFacing)
);

//--- bench/ghostStepTb.sv
`timescale 1ns/10ps

module ghostStepTb;
    import mazePkg::*;
    import ghostPkg::*;

    localparam int numEntries = 12;
    localparam int cycleLimit = numEntries * 20 + 50; // Generous for gaps and stalls

    // One table row, one request
    typedef struct packed {
        tileT       loc;
        dirT        facing;
        modeT       mode;
        logic       rot;
        logic [3:0] wall;
        tileT       pac;
    } stimT;

    logic       sysclk = 1'b0;
    logic       rstN;
    logic       inValid;
    logic       inReady;
    tileT       curLoc;
    dirT        curFacing;
    modeT       mode;
    logic       rotate;
    logic [3:0] wallClear;
    tileT       pacLoc;
    logic       outValid;
    logic       outReady;
    tileT       nextLoc;
    dirT        nextFacing;

    stimT        stimTbl [numEntries];
    tileT        expLocQ [$];   // Scoreboard, filled on acceptance
    dirT         expDirQ [$];
    int          acceptEdgeQ [$];
    logic [15:0] lfsrModel;    // Mirror of the frightened LFSR
    logic [31:0] gapRand;
    logic [31:0] stallRand;
    int          cycleCount = 0;
    int          outCount = 0;

    always #10 sysclk = ~sysclk; // 20 ns period

    ghostStepTop u_dut (
        .sysclk(sysclk), .rstN(rstN), .inValid(inValid), .inReady(inReady),
        .curLoc(curLoc), .curFacing(curFacing), .mode(mode), .rotate(rotate),
        .wallClear(wallClear), .pacLoc(pacLoc), .outValid(outValid),
        .outReady(outReady), .nextLoc(nextLoc), .nextFacing(nextFacing)
    );

    function automatic logic [31:0] lcgNext(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345; // Wraps at 2^32
    endfunction

    // Opposite direction, left/right and up/down pairs
    function automatic dirT backOf(dirT d);
        case (d)
            dirLeft:  return dirRight;
            dirRight: return dirLeft;
            dirUp:    return dirDown;
            default:  return dirUp;
        endcase
    endfunction

    function automatic tileT stepTile(tileT t, dirT d);
        logic [7:0] x;
        logic [7:0] y;
        x = t[15:8];
        y = t[7:0];
        case (d)
            dirLeft:  x = x - 8'd1; // 8-bit wrap
            dirRight: x = x + 8'd1;
            dirUp:    y = y - 8'd1;
            default:  y = y + 8'd1;
        endcase
        return {x, y};
    endfunction

    function automatic int sqDist(tileT a, tileT b);
        int dx;
        int dy;
        dx = int'(a[15:8]) - int'(b[15:8]);
        dy = int'(a[7:0]) - int'(b[7:0]);
        return dx * dx + dy * dy;
    endfunction

    // Reference model, steps the LFSR mirror once per call
    task automatic predict(input stimT s, output tileT eLoc, output dirT eDir);
        dirT        order [4];
        logic [3:0] allowed;
        tileT       target;
        int         best;
        int         d;
        order   = '{dirUp, dirLeft, dirDown, dirRight};
        allowed = s.rot ? (s.wall & backOf(s.facing)) : (s.wall & ~backOf(s.facing));
        case (s.mode)
            modeChase:   target = s.pac;
            modeScatter: target = scatterTarget;
            modeEaten:   target = houseTarget;
            default: begin
                target = s.loc; // Boxed in
                // Walk backwards so the first hit from the start index wins
                for (int k = 3; k >= 0; k--) begin
                    d = (int'(lfsrModel[1:0]) + k) % 4;
                    if (|(allowed & order[d]))
                        target = stepTile(s.loc, order[d]);
                end
            end
        endcase
        lfsrModel = {1'b0, lfsrModel[15:1]} ^ (lfsrModel[0] ? lfsrTaps : 16'h0000);
        eLoc = s.loc;
        eDir = s.facing;
        best = -1;
        for (int k = 0; k < 4; k++) begin
            if (|(allowed & order[k])) begin
                d = sqDist(stepTile(s.loc, order[k]), target);
                if (best < 0 || d < best) begin // Strict, earlier wins a tie
                    best = d;
                    eLoc = stepTile(s.loc, order[k]);
                    eDir = order[k];
                end
            end
        end
    endtask

    task automatic endFail();
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped on first error");
    endtask

    task automatic loadTable();
        stimTbl[0]  = '{{8'd10, 8'd10}, dirRight, modeChase, 1'b0, 4'b1111, {8'd20, 8'd10}};
        stimTbl[1]  = '{{8'd50, 8'd50}, dirUp, modeChase, 1'b0, 4'b1111, {8'd50, 8'd50}};
        stimTbl[2]  = '{{8'd30, 8'd30}, dirDown, modeChase, 1'b0, 4'b1100, {8'd30, 8'd40}};
        stimTbl[3]  = '{{8'd5, 8'd5}, dirLeft, modeChase, 1'b0, 4'b1111, {8'd10, 8'd5}};
        stimTbl[4]  = '{{8'd100, 8'd100}, dirUp, modeScatter, 1'b0, 4'b1111, 16'h0000};
        stimTbl[5]  = '{{8'd101, 8'd110}, dirDown, modeEaten, 1'b0, 4'b1111, 16'h0000};
        stimTbl[6]  = '{{8'd40, 8'd40}, dirRight, modeChase, 1'b1, 4'b1111, {8'd90, 8'd40}};
        stimTbl[7]  = '{{8'd40, 8'd40}, dirUp, modeScatter, 1'b1, 4'b1110, 16'h0000};
        stimTbl[8]  = '{{8'd70, 8'd70}, dirLeft, modeChase, 1'b0, 4'b0100, {8'd1, 8'd1}};
        stimTbl[9]  = '{{8'd60, 8'd60}, dirDown, modeFrightened, 1'b0, 4'b1111, 16'h0000};
        stimTbl[10] = '{{8'd0, 8'd0}, dirLeft, modeFrightened, 1'b0, 4'b1011, 16'h0000};
        stimTbl[11] = '{{8'd255, 8'd3}, dirRight, modeChase, 1'b0, 4'b0110, {8'd0, 8'd3}};
    endtask

    // Monitor and scoreboard, samples settled values at the edge
    always @(posedge sysclk) begin : monitor
        tileT eLoc;
        dirT  eDir;
        int   lat;
        logic expReady;
        stimT req;
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            endFail();
        end
        if (u_dut.uAsserts.failCount != 0) begin
            $display("A bound assertion failed, see the error above");
            endFail();
        end
        if (rstN) begin
            expReady = !(outValid && !outReady); // Refused only behind a stalled result
            assert (inReady == expReady) else begin
                $display("** Error at %0t ns: inReady expected %b got %b",
                         $time, expReady, inReady);
                endFail();
            end
        end
        if (rstN && outValid && outReady) begin
            assert (expLocQ.size() > 0) else begin
                $display("Output transfer at %0t ns with no request outstanding", $time);
                endFail();
            end
            eLoc = expLocQ.pop_front();
            eDir = expDirQ.pop_front();
            lat  = cycleCount - acceptEdgeQ.pop_front();
            assert (nextLoc == eLoc) else begin
                $display("** Error at %0t ns: nextLoc expected %h got %h", $time, eLoc, nextLoc);
                endFail();
            end
            assert (nextFacing == eDir) else begin
                $display("** Error at %0t ns: nextFacing expected %b got %b",
                         $time, eDir, nextFacing);
                endFail();
            end
            if (outCount < 3) begin // Unstalled opening burst
                assert (lat == pipeDepth) else begin
                    $display("** Error at %0t ns: latency expected %0d got %0d",
                             $time, pipeDepth, lat);
                    endFail();
                end
            end
            outCount++;
        end
        if (rstN && inValid && inReady) begin
            req = '{curLoc, curFacing, mode, rotate, wallClear, pacLoc};
            predict(req, eLoc, eDir);
            expLocQ.push_back(eLoc);
            expDirQ.push_back(eDir);
            acceptEdgeQ.push_back(cycleCount);
        end
    end

    // Back-pressure once the first three results are out
    always @(posedge sysclk) begin
        #1;
        if (outCount >= 3) begin
            stallRand = lcgNext(stallRand);
            outReady  = (stallRand[23:22] != 2'b00); // About one stall in four
        end
    end

    initial begin
        rstN      = 1'b0;
        inValid   = 1'b0;
        curLoc    = '0;
        curFacing = dirLeft;
        mode      = modeChase;
        rotate    = 1'b0;
        wallClear = '0;
        pacLoc    = '0;
        outReady  = 1'b1;
        lfsrModel = lfsrSeed;
        gapRand   = 32'd75515;
        stallRand = 32'd75515;
        loadTable();
        repeat (2) @(posedge sysclk);
        #1 rstN = 1'b1;
        for (int i = 0; i < numEntries; i++) begin
            if (i >= 3) begin // First three go back to back
                gapRand = lcgNext(gapRand);
                inValid = 1'b0;
                repeat (gapRand[17:16]) @(posedge sysclk);
                if (gapRand[17:16] != 0)
                    #1;
            end
            curLoc    = stimTbl[i].loc;
            curFacing = stimTbl[i].facing;
            mode      = stimTbl[i].mode;
            rotate    = stimTbl[i].rot;
            wallClear = stimTbl[i].wall;
            pacLoc    = stimTbl[i].pac;
            inValid   = 1'b1;
            do @(posedge sysclk); while (!inReady); // Held until accepted
            #1;
        end
        inValid = 1'b0;
        wait (outCount == numEntries);
        repeat (2) @(posedge sysclk);
        if (u_dut.uAsserts.failCount == 0 && !outValid) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("Extra result pending or assertion errors at end of run");
            endFail();
        end
    end

endmodule

//--- hdl/dirArbiter.sv
`timescale 1ns/10ps

module dirArbiter (
    input  logic          sysclk,
    input  logic          rstN,
    input  logic          advance,
    input  mazePkg::distT distLeft,
    input  mazePkg::distT distRight,
    input  mazePkg::distT distUp,
    input  mazePkg::distT distDown,
    input  logic [3:0]    allowed2,
    input  mazePkg::tileT loc2,
    input  mazePkg::dirT  facing2,
    output mazePkg::tileT nextLoc,
    output mazePkg::dirT  nextFacing
);
    import mazePkg::*;

    logic [3:0] allowed2Q; // Stage 2 side copies, aligned with the distances
    tileT       loc2Q;
    dirT        facing2Q;
    distT       distOrd [4]; // Distances in tie order
    dirT        bestDir;
    logic       anyAllowed;

    always_ff @(posedge sysclk) begin
        if (advance) begin
            allowed2Q <= allowed2;
            loc2Q     <= loc2;
            facing2Q  <= facing2;
        end
    end

    assign distOrd[0] = distUp;
    assign distOrd[1] = distLeft;
    assign distOrd[2] = distDown;
    assign distOrd[3] = distRight;

    // Strict less-than keeps the earlier direction on a tie
    always_comb begin
        distT bestDist;
        bestDist   = distBlocked;
        bestDir    = facing2Q;
        anyAllowed = 1'b0;
        for (int k = 0; k < 4; k++) begin
            if (|(allowed2Q & tieOrder[k])) begin
                if (!anyAllowed || distOrd[k] < bestDist) begin
                    bestDist = distOrd[k];
                    bestDir  = tieOrder[k];
                end
                anyAllowed = 1'b1;
            end
        end
    end

    // Stage 3 result
    always_ff @(posedge sysclk) begin
        if (!rstN) begin
            nextLoc    <= '0;
            nextFacing <= dirLeft;
        end else if (advance) begin
            if (anyAllowed) begin
                nextLoc    <= nbrTile(loc2Q, bestDir);
                nextFacing <= bestDir;
            end else begin
                nextLoc    <= loc2Q; // Nowhere to go, stay put
                nextFacing <= facing2Q;
            end
        end
    end

endmodule

//--- hdl/ghostPkg.sv
package ghostPkg;

    // Ghost behaviour modes
    typedef enum logic [1:0] {
        modeChase,
        modeScatter,
        modeFrightened,
        modeEaten
    } modeT;

    localparam logic [15:0] lfsrSeed = 16'hACE1; // Frightened LFSR start value
    localparam logic [15:0] lfsrTaps = 16'hB400; // Galois taps, right shift

    localparam int pipeDepth = 3; // Stages from request to result

endpackage

//--- hdl/ghostStepTop.sv
`timescale 1ns/10ps

module ghostStepTop (
    input  logic           sysclk,
    input  logic           rstN,
    input  logic           inValid,
    output logic           inReady,
    input  mazePkg::tileT  curLoc,
    input  mazePkg::dirT   curFacing,
    input  ghostPkg::modeT mode,
    input  logic           rotate,
    input  logic [3:0]     wallClear,
    input  mazePkg::tileT  pacLoc,
    output logic           outValid,
    input  logic           outReady,
    output mazePkg::tileT  nextLoc,
    output mazePkg::dirT   nextFacing
);
    import mazePkg::*;

    logic       advance;    // Shared stage enable
    logic [3:0] allowedNow; // Combinational, for the frightened pick
    logic [3:0] allowedQ;
    tileT       targetQ;
    tileT       locQ;
    dirT        facingQ;
    distT       distLeft;
    distT       distRight;
    distT       distUp;
    distT       distDown;

    pipeCtrl uCtrl (
        .sysclk(sysclk), .rstN(rstN), .inValid(inValid), .outReady(outReady),
        .advance(advance), .inReady(inReady), .outValid(outValid)
    );

    pathFilter uFilter (
        .sysclk(sysclk), .rstN(rstN), .advance(advance), .curFacing(curFacing),
        .rotate(rotate), .wallClear(wallClear),
        .allowedNow(allowedNow), .allowedQ(allowedQ)
    );

    targetSelect uTarget (
        .sysclk(sysclk), .rstN(rstN), .advance(advance), .inValid(inValid),
        .mode(mode), .curLoc(curLoc), .pacLoc(pacLoc), .curFacing(curFacing),
        .allowedNow(allowedNow), .targetQ(targetQ), .locQ(locQ), .facingQ(facingQ)
    );

    // One distance unit per neighbour
    tileDistance #(.stepDir(dirLeft)) uLeft (
        .sysclk(sysclk), .advance(advance), .loc(locQ), .target(targetQ),
        .allowed(allowedQ[idxLeft]), .distQ(distLeft)
    );
    tileDistance #(.stepDir(dirRight)) uRight (
        .sysclk(sysclk), .advance(advance), .loc(locQ), .target(targetQ),
        .allowed(allowedQ[idxRight]), .distQ(distRight)
    );
    tileDistance #(.stepDir(dirUp)) uUp (
        .sysclk(sysclk), .advance(advance), .loc(locQ), .target(targetQ),
        .allowed(allowedQ[idxUp]), .distQ(distUp)
    );
    tileDistance #(.stepDir(dirDown)) uDown (
        .sysclk(sysclk), .advance(advance), .loc(locQ), .target(targetQ),
        .allowed(allowedQ[idxDown]), .distQ(distDown)
    );

    dirArbiter uArb (
        .sysclk(sysclk), .rstN(rstN), .advance(advance),
        .distLeft(distLeft), .distRight(distRight), .distUp(distUp), .distDown(distDown),
        .allowed2(allowedQ), .loc2(locQ), .facing2(facingQ), // Re-registered inside
        .nextLoc(nextLoc), .nextFacing(nextFacing)
    );

endmodule

//--- hdl/mazePkg.sv
package mazePkg;

    typedef logic [15:0] tileT; // X in [15:8], y in [7:0]
    typedef logic [16:0] distT; // Squared distance, max 2*255^2 fits

    // One-hot facing, same bit order as the wall-clear port
    typedef enum logic [3:0] {
        dirLeft  = 4'b1000,
        dirRight = 4'b0100,
        dirUp    = 4'b0010,
        dirDown  = 4'b0001
    } dirT;

    localparam int idxLeft  = 3; // Wall-clear and allowed-set bit positions
    localparam int idxRight = 2;
    localparam int idxUp    = 1;
    localparam int idxDown  = 0;

    localparam distT distBlocked = '1; // Never reached by a real distance

    // Byte-wise offsets, each byte wraps on its own
    localparam tileT offLeft  = {8'hFF, 8'h00};
    localparam tileT offRight = {8'h01, 8'h00};
    localparam tileT offUp    = {8'h00, 8'hFF};
    localparam tileT offDown  = {8'h00, 8'h01};

    localparam tileT scatterTarget = {8'd216, 8'd0};   // Top right corner
    localparam tileT houseTarget   = {8'd101, 8'd106}; // Ghost house door

    // Tie priority, also the frightened search order
    localparam dirT tieOrder [4] = '{dirUp, dirLeft, dirDown, dirRight};

    // Reverse table
    function automatic dirT reverseDir(dirT d);
        case (d)
            dirLeft:  return dirRight;
            dirRight: return dirLeft;
            dirUp:    return dirDown;
            dirDown:  return dirUp;
            default:  return d;
        endcase
    endfunction

    // Neighbour tile, x and y wrap modulo 256 independently
    function automatic tileT nbrTile(tileT loc, dirT d);
        tileT off;
        case (d)
            dirLeft:  off = offLeft;
            dirRight: off = offRight;
            dirUp:    off = offUp;
            dirDown:  off = offDown;
            default:  off = '0;
        endcase
        return {loc[15:8] + off[15:8], loc[7:0] + off[7:0]};
    endfunction

endpackage

//--- hdl/pathFilter.sv
`timescale 1ns/10ps

module pathFilter (
    input  logic          sysclk,
    input  logic          rstN,
    input  logic          advance,
    input  mazePkg::dirT  curFacing,
    input  logic          rotate,
    input  logic [3:0]    wallClear,
    output logic [3:0]    allowedNow,
    output logic [3:0]    allowedQ
);
    import mazePkg::*;

    dirT backDir; // Direction the ghost came from

    assign backDir = reverseDir(curFacing);

    always_comb begin
        if (rotate) begin
            allowedNow = wallClear & backDir; // Forced turn, only if clear
        end else begin
            allowedNow = wallClear & ~backDir; // No reversing on a normal step
        end
    end

    // Stage 1 copy of the allowed set
    always_ff @(posedge sysclk) begin
        if (!rstN) begin
            allowedQ <= '0;
        end else if (advance) begin
            allowedQ <= allowedNow;
        end
    end

endmodule

//--- hdl/pipeCtrl.sv
`timescale 1ns/10ps

module pipeCtrl (
    input  logic sysclk,
    input  logic rstN,
    input  logic inValid,
    input  logic outReady,
    output logic advance,
    output logic inReady,
    output logic outValid
);
    import ghostPkg::*;

    logic [pipeDepth-1:0] validSr; // Bit 0 is v1, bit 1 is v2, top bit is outValid

    assign outValid = validSr[pipeDepth-1];
    assign advance  = ~outValid | outReady; // Last stage empty or draining
    assign inReady  = advance;              // Whole pipe moves as one

    always_ff @(posedge sysclk) begin
        if (!rstN) begin
            validSr <= '0;
        end else if (advance) begin
            validSr <= {validSr[pipeDepth-2:0], inValid}; // Shift valids with data
        end
    end

endmodule

//--- hdl/targetSelect.sv
`timescale 1ns/10ps

module targetSelect (
    input  logic           sysclk,
    input  logic           rstN,
    input  logic           advance,
    input  logic           inValid,
    input  ghostPkg::modeT mode,
    input  mazePkg::tileT  curLoc,
    input  mazePkg::tileT  pacLoc,
    input  mazePkg::dirT   curFacing,
    input  logic [3:0]     allowedNow,
    output mazePkg::tileT  targetQ,
    output mazePkg::tileT  locQ,
    output mazePkg::dirT   facingQ
);
    import mazePkg::*;
    import ghostPkg::*;

    logic [15:0] lfsrQ;
    logic [15:0] lfsrNext;
    tileT        frightTarget;
    tileT        targetNow;

    // Galois LFSR, right shift
    assign lfsrNext = lfsrQ[0] ? ((lfsrQ >> 1) ^ lfsrTaps) : (lfsrQ >> 1);

    // First allowed direction, searching cyclically from the random start
    always_comb begin
        logic [1:0] idx;
        logic       found;
        dirT        pick;
        found = 1'b0;
        pick  = dirUp;
        for (int k = 0; k < 4; k++) begin
            idx = lfsrQ[1:0] + 2'(k); // Wraps at 4
            if (!found && |(allowedNow & tieOrder[idx])) begin
                found = 1'b1;
                pick  = tieOrder[idx];
            end
        end
        frightTarget = found ? nbrTile(curLoc, pick) : curLoc; // Boxed in, aim at self
    end

    always_comb begin
        case (mode)
            modeChase:      targetNow = pacLoc;
            modeScatter:    targetNow = scatterTarget;
            modeFrightened: targetNow = frightTarget;
            modeEaten:      targetNow = houseTarget;
            default:        targetNow = curLoc;
        endcase
    end

    // LFSR steps once per accepted request
    always_ff @(posedge sysclk) begin
        if (!rstN) begin
            lfsrQ <= lfsrSeed;
        end else if (advance && inValid) begin
            lfsrQ <= lfsrNext;
        end
    end

    // Stage 1 payload
    always_ff @(posedge sysclk) begin
        if (advance) begin
            targetQ <= targetNow;
            locQ    <= curLoc;
            facingQ <= curFacing;
        end
    end

endmodule

//--- hdl/tileDistance.sv
`timescale 1ns/10ps

module tileDistance #(
    parameter mazePkg::dirT stepDir = mazePkg::dirLeft // Neighbour measured here
) (
    input  logic          sysclk,
    input  logic          advance,
    input  mazePkg::tileT loc,
    input  mazePkg::tileT target,
    input  logic          allowed,
    output mazePkg::distT distQ
);
    import mazePkg::*;

    tileT        nbr;
    logic [7:0]  dx;
    logic [7:0]  dy;
    logic [15:0] dx2;
    logic [15:0] dy2;

    assign nbr = nbrTile(loc, stepDir);

    // Absolute differences keep the squares unsigned
    assign dx  = (nbr[15:8] > target[15:8]) ? nbr[15:8] - target[15:8]
                                              : target[15:8] - nbr[15:8];
    assign dy  = (nbr[7:0] > target[7:0]) ? nbr[7:0] - target[7:0]
                                            : target[7:0] - nbr[7:0];
    assign dx2 = dx * dx;
    assign dy2 = dy * dy;

    always_ff @(posedge sysclk) begin
        if (advance) begin
            distQ <= allowed ? ({1'b0, dx2} + {1'b0, dy2}) : distBlocked; // Stage 2
        end
    end

endmodule

//--- src.f
hdl/mazePkg.sv
hdl/ghostPkg.sv
hdl/pipeCtrl.sv
hdl/pathFilter.sv
hdl/targetSelect.sv
hdl/tileDistance.sv
hdl/dirArbiter.sv
hdl/ghostStepTop.sv
bench/ghostStepAsserts.sv
bench/ghostStepTb.sv
